/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the simulation log
rm -f sim.log
verilator --binary --timing --assert --top-module tbDualIssueCore -f vlog.f \
    -o tbDualIssueCore > build.log 2>&1 && ./obj_dir/tbDualIssueCore > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/alu.sv */
module alu (
    input  isaPkg::word_t  operandA,
    input  isaPkg::word_t  operandB,
    input  isaPkg::shamt_t shamt,
    input  isaPkg::aluOp_t aluOp,
    output isaPkg::word_t  result
);
    import isaPkg::*;

    logic lessThan;

    // signed compare for slt
    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB;
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluSlt: begin
                result = word_t'(lessThan);
            end
            // shifts work on the rt operand
            aluSll: begin
                result = operandB << shamt;
            end
            aluSrl: begin
                result = operandB >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* src/controlUnit.sv */
module controlUnit (
    input  isaPkg::opcode_t opcode,
    input  isaPkg::funct_t  funct,
    output isaPkg::aluOp_t  aluOp,
    output logic            useImm,
    output logic            destIsRt,
    output logic            regWrite
);
    import isaPkg::*;

    always_comb begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        destIsRt = 1'b0;
        regWrite = 1'b0;
        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                case (funct)
                    functAdd: aluOp = aluAdd;
                    functSub: aluOp = aluSub;
                    functAnd: aluOp = aluAnd;
                    functOr:  aluOp = aluOr;
                    functSlt: aluOp = aluSlt;
                    functSll: aluOp = aluSll;
                    functSrl: aluOp = aluSrl;
                    // unknown function passes through as a no-write
                    default:  regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                aluOp    = aluAdd;
                useImm   = 1'b1;
                destIsRt = 1'b1;
                regWrite = 1'b1;
            end
            opAndi: begin
                aluOp    = aluAnd;
                useImm   = 1'b1;
                destIsRt = 1'b1;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp    = aluOr;
                useImm   = 1'b1;
                destIsRt = 1'b1;
                regWrite = 1'b1;
            end
            default: regWrite = 1'b0;
        endcase
    end

endmodule

/* src/dualIssueCore.sv */
module dualIssueCore (
    input  logic            clk,
    input  logic            arstN,
    input  logic            enable,
    input  logic            issueValid,
    input  isaPkg::word_t   instr1,
    input  isaPkg::word_t   instr2,
    output logic            wbValid1,
    output logic            wbValid2,
    output logic            wbWriteEn1,
    output logic            wbWriteEn2,
    output isaPkg::regIdx_t wbReg1,
    output isaPkg::regIdx_t wbReg2,
    output isaPkg::word_t   wbData1,
    output isaPkg::word_t   wbData2
);
    import isaPkg::*;
    import pipePkg::*;

    regIdx_t readAddr [laneCount*2];
    word_t   readData [laneCount*2];

    laneResultIf laneResult1 ();
    laneResultIf laneResult2 ();

    // lane 1 holds the older instruction of the pair
    issueLane issueLane1_inst (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .issueValid (issueValid),
        .instr      (instr1),
        .rsAddr     (readAddr[0]),
        .rtAddr     (readAddr[1]),
        .rsData     (readData[0]),
        .rtData     (readData[1]),
        .peer1      (laneResult1),
        .peer2      (laneResult2),
        .result     (laneResult1)
    );

    issueLane issueLane2_inst (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .issueValid (issueValid),
        .instr      (instr2),
        .rsAddr     (readAddr[2]),
        .rtAddr     (readAddr[3]),
        .rsData     (readData[2]),
        .rtData     (readData[3]),
        .peer1      (laneResult1),
        .peer2      (laneResult2),
        .result     (laneResult2)
    );

    registerFile registerFile_inst (
        .clk      (clk),
        .arstN    (arstN),
        .enable   (enable),
        .readAddr (readAddr),
        .readData (readData),
        .write1   (laneResult1),
        .write2   (laneResult2)
    );

    // nothing retires while frozen
    assign wbValid1   = laneResult1.valid && enable;
    assign wbValid2   = laneResult2.valid && enable;
    assign wbWriteEn1 = laneResult1.writeEn;
    assign wbWriteEn2 = laneResult2.writeEn;
    assign wbReg1     = laneResult1.dest;
    assign wbReg2     = laneResult2.dest;
    assign wbData1    = laneResult1.data;
    assign wbData2    = laneResult2.data;

endmodule

/* src/isaPkg.sv */
package isaPkg;

    // widths with a meaning in the instruction set
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [2:0]  aluOp_t;

    // field positions in an instruction word
    localparam int opcodeMsb = 31;
    localparam int rsLsb     = 21;
    localparam int rtLsb     = 16;
    localparam int rdLsb     = 11;
    localparam int shamtLsb  = 6;

    // supported opcodes
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opAndi  = 6'h0C;
    localparam opcode_t opOri   = 6'h0D;

    // R-type function codes
    localparam funct_t functAdd = 6'h20;
    localparam funct_t functSub = 6'h22;
    localparam funct_t functAnd = 6'h24;
    localparam funct_t functOr  = 6'h25;
    localparam funct_t functSlt = 6'h2A;
    localparam funct_t functSll = 6'h00;
    localparam funct_t functSrl = 6'h02;

    // ALU operations
    localparam aluOp_t aluAdd = 3'd0;
    localparam aluOp_t aluSub = 3'd1;
    localparam aluOp_t aluAnd = 3'd2;
    localparam aluOp_t aluOr  = 3'd3;
    localparam aluOp_t aluSlt = 3'd4;
    localparam aluOp_t aluSll = 3'd5;
    localparam aluOp_t aluSrl = 3'd6;

endpackage

/* src/issueLane.sv */
module issueLane (
    input  logic            clk,
    input  logic            arstN,
    input  logic            enable,
    input  logic            issueValid,
    input  isaPkg::word_t   instr,
    output isaPkg::regIdx_t rsAddr,
    output isaPkg::regIdx_t rtAddr,
    input  isaPkg::word_t   rsData,
    input  isaPkg::word_t   rtData,
    laneResultIf.sink       peer1,
    laneResultIf.sink       peer2,
    laneResultIf.result     result
);
    import isaPkg::*;
    import pipePkg::*;

    // decode stage
    logic    decValid;
    word_t   decInstr;
    opcode_t decOpcode;
    funct_t  decFunct;
    regIdx_t decRd;
    imm_t    decImm;
    word_t   decImmExt;
    aluOp_t  decAluOp;
    logic    decUseImm;
    logic    decDestIsRt;
    logic    decRegWrite;

    // execute stage
    logic    exValid;
    logic    exRegWrite;
    aluOp_t  exAluOp;
    logic    exUseImm;
    regIdx_t exRs;
    regIdx_t exRt;
    regIdx_t exDest;
    shamt_t  exShamt;
    word_t   exRsData;
    word_t   exRtData;
    word_t   exImm;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   operandA;
    word_t   rtOperand;
    word_t   operandB;
    word_t   aluResult;

    // lane 2 of the previous pair is newer than lane 1
    function automatic fwdSel_t pickSource(
        input regIdx_t addr,
        input logic    writeEn1,
        input regIdx_t dest1,
        input logic    writeEn2,
        input regIdx_t dest2
    );
        if (writeEn2 && dest2 == addr) begin
            return fwdLane2;
        end
        if (writeEn1 && dest1 == addr) begin
            return fwdLane1;
        end
        return fwdRegFile;
    endfunction

    function automatic word_t selectOperand(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   lane1Val,
        input word_t   lane2Val
    );
        case (sel)
            fwdLane1: return lane1Val;
            fwdLane2: return lane2Val;
            default:  return regVal;
        endcase
    endfunction

    assign decOpcode = decInstr[opcodeMsb -: $bits(opcode_t)];
    assign decFunct  = decInstr[$bits(funct_t)-1:0];
    assign rsAddr    = decInstr[rsLsb +: $bits(regIdx_t)];
    assign rtAddr    = decInstr[rtLsb +: $bits(regIdx_t)];
    assign decRd     = decInstr[rdLsb +: $bits(regIdx_t)];
    assign decImm    = decInstr[$bits(imm_t)-1:0];
    assign decImmExt = {{($bits(word_t) - $bits(imm_t)){decImm[$bits(imm_t)-1]}}, decImm};

    controlUnit controlUnit_inst (
        .opcode   (decOpcode),
        .funct    (decFunct),
        .aluOp    (decAluOp),
        .useImm   (decUseImm),
        .destIsRt (decDestIsRt),
        .regWrite (decRegWrite)
    );

    // operands of the previous pair come straight from writeback
    assign fwdA = pickSource(exRs, peer1.writeEn, peer1.dest, peer2.writeEn, peer2.dest);
    assign fwdB = pickSource(exRt, peer1.writeEn, peer1.dest, peer2.writeEn, peer2.dest);
    assign operandA  = selectOperand(fwdA, exRsData, peer1.data, peer2.data);
    assign rtOperand = selectOperand(fwdB, exRtData, peer1.data, peer2.data);
    assign operandB  = exUseImm ? exImm : rtOperand;

    alu alu_inst (
        .operandA (operandA),
        .operandB (operandB),
        .shamt    (exShamt),
        .aluOp    (exAluOp),
        .result   (aluResult)
    );

    // stage valids and write enables
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid       <= 1'b0;
            exValid        <= 1'b0;
            exRegWrite     <= 1'b0;
            result.valid   <= 1'b0;
            result.writeEn <= 1'b0;
        end else if (enable) begin
            decValid       <= issueValid;
            exValid        <= decValid;
            exRegWrite     <= decRegWrite;
            result.valid   <= exValid;
            result.writeEn <= exValid && exRegWrite && (exDest != '0);
        end
    end

    // instruction, operands and result
    always_ff @(posedge clk) begin
        if (enable) begin
            decInstr    <= instr;
            exAluOp     <= decAluOp;
            exUseImm    <= decUseImm;
            exRs        <= rsAddr;
            exRt        <= rtAddr;
            exDest      <= decDestIsRt ? rtAddr : decRd;
            exShamt     <= decInstr[shamtLsb +: $bits(shamt_t)];
            exRsData    <= rsData;
            exRtData    <= rtData;
            exImm       <= decImmExt;
            result.dest <= exDest;
            result.data <= aluResult;
        end
    end

    // r0 is never written, and only a valid slot writes
    assert property (@(posedge clk) disable iff (!arstN)
        result.writeEn |-> result.valid && (result.dest != '0));

endmodule

/* src/laneResultIf.sv */
interface laneResultIf;
    import isaPkg::*;

    logic    valid;
    logic    writeEn;
    regIdx_t dest;
    word_t   data;

    // producing lane
    modport result (output valid, output writeEn, output dest, output data);

    // register file and forwarding
    modport sink (input valid, input writeEn, input dest, input data);

endinterface

/* src/pipePkg.sv */
package pipePkg;

    // where an execute operand comes from
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t fwdRegFile = 2'd0;
    localparam fwdSel_t fwdLane1   = 2'd1;
    localparam fwdSel_t fwdLane2   = 2'd2;

    // two lanes, each with two read ports and one write port
    localparam int laneCount = 2;
    localparam int regCount  = 32;

endpackage

/* src/registerFile.sv */
module registerFile (
    input  logic            clk,
    input  logic            arstN,
    input  logic            enable,
    input  isaPkg::regIdx_t readAddr [pipePkg::laneCount*2],
    output isaPkg::word_t   readData [pipePkg::laneCount*2],
    laneResultIf.sink       write1,
    laneResultIf.sink       write2
);
    import isaPkg::*;
    import pipePkg::*;

    // r0 has no storage
    word_t [regCount-1:1] regs;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '0;
        end else if (enable) begin
            for (int i = 1; i < regCount; i++) begin
                // lane 2 is later in program order and wins
                if (write2.writeEn && write2.dest == regIdx_t'(i)) begin
                    regs[i] <= write2.data;
                end else if (write1.writeEn && write1.dest == regIdx_t'(i)) begin
                    regs[i] <= write1.data;
                end
            end
        end
    end

    // write-first bypass for the pair two back
    always_comb begin
        for (int p = 0; p < laneCount*2; p++) begin
            if (readAddr[p] == '0) begin
                readData[p] = '0;
            end else if (write2.writeEn && write2.dest == readAddr[p]) begin
                readData[p] = write2.data;
            end else if (write1.writeEn && write1.dest == readAddr[p]) begin
                readData[p] = write1.data;
            end else begin
                readData[p] = regs[readAddr[p]];
            end
        end
    end

    // frozen pipeline leaves the architectural state alone
    assert property (@(posedge clk) disable iff (!arstN)
        !enable |=> $stable(regs));

endmodule

/* verification/tbDualIssueCore.sv */
module tbDualIssueCore;
    import isaPkg::*;

    // expected writeback of one issued pair
    typedef struct packed {
        logic [31:0] stamp;
        logic        writeEn1;
        regIdx_t     dest1;
        word_t       data1;
        logic        writeEn2;
        regIdx_t     dest2;
        word_t       data2;
    } pairResult_t;

    logic    clk;
    logic    arstN;
    logic    enable;
    logic    issueValid;
    word_t   instr1;
    word_t   instr2;
    logic    wbValid1;
    logic    wbValid2;
    logic    wbWriteEn1;
    logic    wbWriteEn2;
    regIdx_t wbReg1;
    regIdx_t wbReg2;
    word_t   wbData1;
    word_t   wbData2;

    word_t       refRegs [32];
    pairResult_t pending [$];
    logic [31:0] enabledEdges;
    logic [31:0] lfsrState;
    word_t       lastData1;
    word_t       lastData2;
    int          mismatchCount;
    int          failureCount;

    dualIssueCore dualIssueCore_inst (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .issueValid (issueValid),
        .instr1     (instr1),
        .instr2     (instr2),
        .wbValid1   (wbValid1),
        .wbValid2   (wbValid2),
        .wbWriteEn1 (wbWriteEn1),
        .wbWriteEn2 (wbWriteEn2),
        .wbReg1     (wbReg1),
        .wbReg2     (wbReg2),
        .wbData1    (wbData1),
        .wbData2    (wbData2)
    );

    always #20 clk = ~clk;

    function automatic word_t encodeR(input funct_t fn, input regIdx_t rd, input regIdx_t rs,
                                      input regIdx_t rt, input shamt_t sh);
        return {opRType, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encodeI(input opcode_t op, input regIdx_t rt, input regIdx_t rs,
                                      input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // galois LFSR, one step per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // small register range so that dependences are frequent
    function automatic word_t randomInstr();
        logic [1:0] kind;
        logic [2:0] sel;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        funct_t     fn;
        word_t      ins;
        kind = 2'(randomBits(2));
        rs = regIdx_t'(randomBits(3));
        rt = regIdx_t'(randomBits(3));
        rd = regIdx_t'(randomBits(3));
        sel = 3'(randomBits(3));
        case (sel)
            3'd0: fn = functAdd;
            3'd1: fn = functSub;
            3'd2: fn = functAnd;
            3'd3: fn = functOr;
            3'd4: fn = functSlt;
            3'd5: fn = functSll;
            3'd6: fn = functSrl;
            default: fn = 6'h08;
        endcase
        case (kind)
            2'd0: ins = encodeR(fn, rd, rs, rt, shamt_t'(randomBits(5)));
            2'd1: ins = encodeI(opAddi, rt, rs, imm_t'(randomBits(16)));
            2'd2: ins = encodeI(opAndi, rt, rs, imm_t'(randomBits(16)));
            default: ins = encodeI(opOri, rt, rs, imm_t'(randomBits(16)));
        endcase
        return ins;
    endfunction

    // reference result of one instruction from the state before its pair
    function automatic void modelLane(input word_t ins, output logic writeEn,
                                      output regIdx_t dest, output word_t data);
        word_t a;
        word_t b;
        word_t imm;
        logic  writes;
        a = refRegs[ins[25:21]];
        b = refRegs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        writes = 1'b1;
        dest = ins[15:11];
        data = '0;
        case (ins[31:26])
            opRType: begin
                case (ins[5:0])
                    functAdd: data = a + b;
                    functSub: data = a - b;
                    functAnd: data = a & b;
                    functOr:  data = a | b;
                    functSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    functSll: data = b << ins[10:6];
                    functSrl: data = b >> ins[10:6];
                    default:  writes = 1'b0;
                endcase
            end
            opAddi: begin
                dest = ins[20:16];
                data = a + imm;
            end
            opAndi: begin
                dest = ins[20:16];
                data = a & imm;
            end
            opOri: begin
                dest = ins[20:16];
                data = a | imm;
            end
            default: writes = 1'b0;
        endcase
        writeEn = writes && (dest != '0);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            mismatchCount++;
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // model follows every pair the DUT actually takes
    always @(posedge clk) begin : recordIssue
        pairResult_t entry;
        if (arstN && enable) begin
            enabledEdges = enabledEdges + 1;
            if (issueValid) begin
                entry.stamp = enabledEdges;
                modelLane(instr1, entry.writeEn1, entry.dest1, entry.data1);
                modelLane(instr2, entry.writeEn2, entry.dest2, entry.data2);
                // lane 2 is later in program order
                if (entry.writeEn1) begin
                    refRegs[entry.dest1] = entry.data1;
                end
                if (entry.writeEn2) begin
                    refRegs[entry.dest2] = entry.data2;
                end
                pending.push_back(entry);
            end
        end
    end

    always @(negedge clk) begin : compareResults
        pairResult_t entry;
        if (arstN) begin
            if (!enable) begin
                assert (!wbValid1 && !wbValid2) else begin
                    failureCount++;
                    $display("wbValid was high at time %0t while enable was low", $time);
                end
            end
            assert (wbValid1 === wbValid2) else begin
                failureCount++;
                $display("the two lanes disagree on wbValid at time %0t", $time);
            end
            if (wbValid1) begin
                assert (pending.size() != 0) else begin
                    failureCount++;
                    $display("a result appeared at time %0t with no pair issued", $time);
                end
                if (pending.size() != 0) begin
                    entry = pending.pop_front();
                    checkValue("result edge", enabledEdges, entry.stamp + 2);
                    checkValue("wbWriteEn1", 32'(wbWriteEn1), 32'(entry.writeEn1));
                    checkValue("wbWriteEn2", 32'(wbWriteEn2), 32'(entry.writeEn2));
                    if (entry.writeEn1) begin
                        checkValue("wbReg1", 32'(wbReg1), 32'(entry.dest1));
                        checkValue("wbData1", wbData1, entry.data1);
                    end
                    if (entry.writeEn2) begin
                        checkValue("wbReg2", 32'(wbReg2), 32'(entry.dest2));
                        checkValue("wbData2", wbData2, entry.data2);
                    end
                    lastData1 = wbData1;
                    lastData2 = wbData2;
                end
            end
        end
    end

    task automatic issuePair(input word_t first, input word_t second);
        @(posedge clk);
        instr1 <= first;
        instr2 <= second;
        issueValid <= 1'b1;
    endtask

    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        issueValid <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while (pending.size() != 0 && cycles < 20);
        assert (pending.size() == 0) else begin
            failureCount++;
            $display("timed out at %0t waiting for %0d results", $time, pending.size());
        end
    endtask

    task automatic randomStream(input int pairs);
        repeat (pairs) begin
            issuePair(randomInstr(), randomInstr());
        end
    endtask

    task automatic testReset();
        repeat (4) begin
            @(negedge clk);
            assert (!wbValid1 && !wbValid2) else begin
                failureCount++;
                $display("wbValid went high at time %0t before the first issue", $time);
            end
        end
        issuePair(encodeI(opAddi, 5'd5, 5'd0, 16'h1234), encodeR(functOr, 5'd9, 5'd10, 5'd11, 5'd0));
        waitForDrain();
        checkValue("wbData1", lastData1, 32'h0000_1234);
        checkValue("wbData2", lastData2, 32'h0);
    endtask

    task automatic testAllOps();
        issuePair(encodeI(opAddi, 5'd1, 5'd0, 16'd100), encodeI(opAddi, 5'd2, 5'd0, 16'hFFF9));
        waitForDrain();
        issuePair(encodeR(functAdd, 5'd3, 5'd1, 5'd2, 5'd0), encodeR(functSub, 5'd4, 5'd1, 5'd2, 5'd0));
        issuePair(encodeR(functAnd, 5'd5, 5'd1, 5'd2, 5'd0), encodeR(functOr, 5'd6, 5'd1, 5'd2, 5'd0));
        issuePair(encodeR(functSlt, 5'd7, 5'd2, 5'd1, 5'd0), encodeR(functSlt, 5'd8, 5'd1, 5'd2, 5'd0));
        issuePair(encodeR(functSll, 5'd9, 5'd0, 5'd1, 5'd4), encodeR(functSrl, 5'd10, 5'd0, 5'd2, 5'd28));
        issuePair(encodeI(opAndi, 5'd11, 5'd2, 16'h00F0), encodeI(opOri, 5'd12, 5'd1, 16'h8001));
        waitForDrain();
    endtask

    task automatic testForwarding();
        issuePair(encodeI(opAddi, 5'd1, 5'd0, 16'd5), encodeI(opAddi, 5'd2, 5'd0, 16'd9));
        issuePair(encodeR(functAdd, 5'd3, 5'd1, 5'd2, 5'd0), encodeR(functSub, 5'd4, 5'd2, 5'd1, 5'd0));
        // r1 and r2 come two pairs back, through the bypass
        issuePair(encodeR(functAdd, 5'd5, 5'd3, 5'd1, 5'd0), encodeR(functOr, 5'd6, 5'd4, 5'd2, 5'd0));
        issuePair(encodeR(functSll, 5'd7, 5'd0, 5'd5, 5'd2), encodeI(opAddi, 5'd8, 5'd6, 16'd1));
        waitForDrain();
    endtask

    task automatic testPairRules();
        issuePair(encodeI(opAddi, 5'd1, 5'd0, 16'h0040), encodeI(opAddi, 5'd3, 5'd0, 16'h0000));
        waitForDrain();
        // lane 2 reads r1 from before the pair
        issuePair(encodeI(opAddi, 5'd1, 5'd0, 16'h0011), encodeI(opAddi, 5'd2, 5'd1, 16'd1));
        waitForDrain();
        checkValue("wbData2", lastData2, 32'h0000_0041);
        issuePair(encodeI(opAddi, 5'd3, 5'd0, 16'd7), encodeI(opAddi, 5'd3, 5'd0, 16'd9));
        issuePair(encodeR(functAdd, 5'd4, 5'd3, 5'd0, 5'd0), encodeR(functAdd, 5'd5, 5'd0, 5'd3, 5'd0));
        waitForDrain();
        checkValue("wbData1", lastData1, 32'd9);
        checkValue("wbData2", lastData2, 32'd9);
        issuePair(encodeR(functAdd, 5'd6, 5'd3, 5'd0, 5'd0), encodeI(opAddi, 5'd0, 5'd0, 16'd5));
        issuePair(encodeR(functAdd, 5'd0, 5'd1, 5'd1, 5'd0), encodeI(6'h23, 5'd1, 5'd0, 16'd4));
        issuePair(encodeR(6'h08, 5'd1, 5'd3, 5'd3, 5'd0), encodeR(functAdd, 5'd7, 5'd1, 5'd0, 5'd0));
        issuePair(encodeR(functAdd, 5'd8, 5'd0, 5'd0, 5'd0), encodeR(functOr, 5'd9, 5'd1, 5'd0, 5'd0));
        waitForDrain();
        checkValue("wbData2", lastData2, 32'h0000_0011);
    endtask

    task automatic testFreeze();
        int holdCycles;
        holdCycles = 1 + int'(randomBits(3));
        randomStream(12);
        @(posedge clk);
        enable <= 1'b0;
        // new pairs keep arriving while frozen and must be ignored
        for (int i = 0; i < holdCycles; i++) begin
            instr1 <= randomInstr();
            instr2 <= randomInstr();
            @(posedge clk);
        end
        enable <= 1'b1;
        randomStream(12);
        waitForDrain();
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        enable = 1'b1;
        issueValid = 1'b0;
        instr1 = '0;
        instr2 = '0;
        lfsrState = 32'd52;
        enabledEdges = '0;
        lastData1 = '0;
        lastData2 = '0;
        mismatchCount = 0;
        failureCount = 0;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        testReset();
        testAllOps();
        testForwarding();
        testPairRules();
        testFreeze();
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/isaPkg.sv
src/pipePkg.sv
src/laneResultIf.sv
src/controlUnit.sv
src/alu.sv
src/issueLane.sv
src/registerFile.sv
src/dualIssueCore.sv
verification/tbDualIssueCore.sv
